/* logic/sprite_pkg.sv */
// panel timing for the 480x272 rgb lcd
// sprite geometry and rgb565 colours
`default_nettype none

package sprite_pkg;

	localparam int CORDW = 16;  // signed screen coordinate bits

	// visible area
	localparam int H_RES = 480;
	localparam int V_RES = 272;

	// horizontal blanking in pixels
	localparam int H_FP   = 8;
	localparam int H_SYNC = 4;
	localparam int H_BP   = 33;  // 525 pixels per line

	// vertical blanking in lines
	localparam int V_FP   = 4;
	localparam int V_SYNC = 4;
	localparam int V_BP   = 6;  // 286 lines per frame

	// counters start negative so the visible area begins at zero
	localparam int H_STA = -(H_FP + H_SYNC + H_BP);
	localparam int V_STA = -(V_FP + V_SYNC + V_BP);

	// sync windows, front porch comes first
	localparam int H_SYNC_STA = H_STA + H_FP;
	localparam int H_SYNC_END = H_SYNC_STA + H_SYNC - 1;
	localparam int V_SYNC_STA = V_STA + V_FP;
	localparam int V_SYNC_END = V_SYNC_STA + V_SYNC - 1;

	// sprite bitmap
	localparam int SPR_WIDTH  = 8;
	localparam int SPR_HEIGHT = 8;
	localparam int SPR_SCALE  = 3;  // 2^3 = 8x
	localparam int SPR_W_PIX  = SPR_WIDTH << SPR_SCALE;   // 64 on screen
	localparam int SPR_H_PIX  = SPR_HEIGHT << SPR_SCALE;
	localparam int SPR_ADDRW  = $clog2(SPR_HEIGHT);  // row address
	localparam int SPR_COLW   = $clog2(SPR_WIDTH);   // column index
	localparam     SPR_FILE   = "logic/letter_f.mem";

	// rgb565 colours
	localparam logic [15:0] COL_FG = 16'hF600;  // yellow
	localparam logic [15:0] COL_BG = 16'h118E;  // blue

endpackage

`default_nettype wire

/* logic/display_if.sv */
// display coordinates and timing strobes
// one source, any number of sinks
`default_nettype none

interface display_if import sprite_pkg::*; ();

	logic signed [CORDW-1:0] sx;  // screen x, negative in blanking
	logic signed [CORDW-1:0] sy;  // screen y
	logic hsync;  // active low
	logic vsync;  // active low
	logic de;     // visible pixel
	logic line;   // first pixel of each line
	logic frame;  // first pixel of each frame

	// timing generator side
	modport source (
		output sx, sy, hsync, vsync, de, line, frame
	);

	// sprite engine and painter side
	modport sink (
		input sx, sy, hsync, vsync, de, line, frame
	);

endinterface

`default_nettype wire

/* logic/display_timing.sv */
// display timing generator
// signed coordinates, syncs, data enable, line and frame strobes
`default_nettype none

module display_timing import sprite_pkg::*; (
	input  wire logic clk_pix,
	input  wire logic rst_n,
	display_if.source disp
);

	// running counters, every output is registered from these
	logic signed [CORDW-1:0] x;
	logic signed [CORDW-1:0] y;

	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			x <= CORDW'(H_STA);
			y <= CORDW'(V_STA);
		end else if (x == H_RES-1) begin  // end of line
			x <= CORDW'(H_STA);
			if (y == V_RES-1) begin  // end of frame
				y <= CORDW'(V_STA);
			end else begin
				y <= y + CORDW'(1);
			end
		end else begin
			x <= x + CORDW'(1);
		end
	end

	// registered outputs, sx and sy line up with the strobes
	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			disp.sx    <= CORDW'(H_STA);
			disp.sy    <= CORDW'(V_STA);
			disp.hsync <= 1'b1;  // inactive
			disp.vsync <= 1'b1;
			disp.de    <= 1'b0;
			disp.line  <= 1'b0;
			disp.frame <= 1'b0;
		end else begin
			disp.sx <= x;
			disp.sy <= y;

			// syncs low inside their windows
			disp.hsync <= !(x >= H_SYNC_STA && x <= H_SYNC_END);
			disp.vsync <= !(y >= V_SYNC_STA && y <= V_SYNC_END);

			// visible area is the non-negative quadrant
			disp.de <= (x >= 0) && (y >= 0);

			disp.line  <= (x == H_STA);
			disp.frame <= (x == H_STA) && (y == V_STA);
		end
	end

endmodule

`default_nettype wire

/* logic/sprite_fsm.sv */
// sprite engine for one scaled 1-bit bitmap
// row prefetch per line, horizontal and vertical scale counters
`default_nettype none

module sprite_fsm import sprite_pkg::*; (
	input  wire logic                    clk_pix,
	input  wire logic                    rst_n,
	display_if.sink                      disp,
	input  wire logic signed [CORDW-1:0] sprx,
	input  wire logic signed [CORDW-1:0] spry,
	output      logic [SPR_ADDRW-1:0]    rom_addr,
	input  wire logic [SPR_WIDTH-1:0]    rom_data,
	output      logic                    drawing,  // one cycle after its coordinate
	output      logic                    pix
);

	enum logic [2:0] {IDLE, REG_POS, WAIT_POS, DRAW, NEXT_LINE, DONE} state;

	logic signed [CORDW-1:0] spr_x;  // position for the current frame
	logic signed [CORDW-1:0] spr_y;
	logic signed [CORDW-1:0] dx;     // offset of the next pixel
	logic signed [CORDW-1:0] dy;     // offset of this line
	logic in_line;    // line crosses the sprite
	logic first_row;  // top of sprite or top of frame
	logic [SPR_ADDRW-1:0] row;       // bitmap row
	logic [SPR_ADDRW-1:0] row_next;
	logic [SPR_SCALE-1:0] cnt_y;     // vertical scale
	logic [SPR_COLW-1:0]  col;       // bitmap column
	logic [SPR_SCALE-1:0] cnt_x;     // horizontal scale
	logic [SPR_WIDTH-1:0] bits;      // row being shifted out, msb first

	always_comb begin
		dy = disp.sy - spr_y;
		dx = disp.sx + CORDW'(1) - spr_x;
		in_line = (dy >= 0) && (dy < SPR_H_PIX);
		// sprite may start above the first line of the frame
		first_row = (dy == 0) || (disp.sy == V_STA);
		row_next = first_row ? dy[SPR_SCALE +: SPR_ADDRW] : row;
	end

	// stable for the whole line, data ready on the first WAIT_POS cycle
	assign rom_addr = row_next;

	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			state   <= IDLE;
			drawing <= 1'b0;
			spr_x   <= '0;
			spr_y   <= '0;
			row     <= '0;
			cnt_y   <= '0;
			col     <= '0;
			cnt_x   <= '0;
		end else begin
			if (disp.frame) begin  // new position from next frame only
				spr_x <= sprx;
				spr_y <= spry;
			end
			drawing <= 1'b0;

			case (state)
				IDLE: if (disp.line) state <= REG_POS;
				REG_POS: begin  // sx is H_STA+1 here
					if (in_line) begin
						row <= row_next;
						if (first_row) cnt_y <= dy[SPR_SCALE-1:0];
						state <= WAIT_POS;
					end else begin
						state <= (dy < 0) ? IDLE : DONE;  // above or below
					end
				end
				WAIT_POS: begin
					if (disp.sx == H_RES-1 || dx >= SPR_W_PIX) begin
						state <= NEXT_LINE;  // nothing left to show
					end else if (dx >= 0) begin  // left edge next, maybe clipped
						col   <= dx[SPR_SCALE +: SPR_COLW];
						cnt_x <= dx[SPR_SCALE-1:0];
						state <= DRAW;
					end
				end
				DRAW: begin
					drawing <= 1'b1;
					cnt_x <= cnt_x + 1'b1;
					if (cnt_x == '1) col <= col + 1'b1;
					// stop at the sprite edge or the screen edge
					if (disp.sx == H_RES-1 || (col == '1 && cnt_x == '1)) begin
						state <= NEXT_LINE;
					end
				end
				NEXT_LINE: begin
					cnt_y <= cnt_y + 1'b1;
					if (cnt_y == '1) row <= row + 1'b1;
					if (disp.line) begin  // right edge clip lands on line start
						state <= REG_POS;
					end else if (row == '1 && cnt_y == '1) begin
						state <= DONE;
					end else begin
						state <= IDLE;
					end
				end
				DONE: if (disp.frame) state <= REG_POS;  // frame implies line
				default: state <= IDLE;
			endcase
		end
	end

	// bitmap shifter
	always_ff @(posedge clk_pix) begin
		if (state == WAIT_POS) begin
			bits <= rom_data << dx[SPR_SCALE +: SPR_COLW];  // skip clipped columns
		end else if (state == DRAW && cnt_x == '1) begin
			bits <= bits << 1;
		end
		pix <= bits[SPR_WIDTH-1];
	end

endmodule

`default_nettype wire

/* logic/sprite_rom.sv */
// sprite bitmap memory
// one row per address, registered read
`default_nettype none

module sprite_rom import sprite_pkg::*; (
	input  wire logic                 clk_pix,
	input  wire logic [SPR_ADDRW-1:0] rom_addr,
	output      logic [SPR_WIDTH-1:0] rom_data
);

	// leftmost digit of a file row lands in the msb
	logic [SPR_WIDTH-1:0] mem [SPR_HEIGHT];

	initial begin
		$readmemb(SPR_FILE, mem);
	end

	always_ff @(posedge clk_pix) begin
		rom_data <= mem[rom_addr];  // one cycle latency
	end

endmodule

`default_nettype wire

/* logic/colour_paint.sv */
// colour select and output register stage
// sync alignment and blanking to black
`default_nettype none

module colour_paint import sprite_pkg::*; (
	input  wire logic clk_pix,
	input  wire logic rst_n,
	display_if.sink   disp,
	input  wire logic drawing,
	input  wire logic pix,
	output      logic vga_hsync,
	output      logic vga_vsync,
	output      logic vga_de,
	output      logic [4:0] vga_r,
	output      logic [5:0] vga_g,
	output      logic [4:0] vga_b
);

	logic hsync_d;  // aligned with drawing and pix
	logic vsync_d;
	logic de_d;
	logic [15:0] colour;  // rgb565

	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			hsync_d <= 1'b1;
			vsync_d <= 1'b1;
			de_d    <= 1'b0;
		end else begin
			hsync_d <= disp.hsync;
			vsync_d <= disp.vsync;
			de_d    <= disp.de;
		end
	end

	// yellow letter on blue
	always_comb colour = (drawing && pix) ? COL_FG : COL_BG;

	always_ff @(posedge clk_pix) begin
		if (!rst_n) begin
			vga_hsync <= 1'b1;
			vga_vsync <= 1'b1;
			vga_de    <= 1'b0;
			vga_r     <= '0;
			vga_g     <= '0;
			vga_b     <= '0;
		end else begin
			vga_hsync <= hsync_d;
			vga_vsync <= vsync_d;
			vga_de    <= de_d;
			vga_r     <= de_d ? colour[15:11] : '0;  // black in blanking
			vga_g     <= de_d ? colour[10:5]  : '0;
			vga_b     <= de_d ? colour[4:0]   : '0;
		end
	end

endmodule

`default_nettype wire

/* logic/sprite_display_top.sv */
// sprite display top level
// timing, sprite engine, bitmap memory and painter
`default_nettype none

module sprite_display_top import sprite_pkg::*; (
	input  wire logic                    clk_pix,
	input  wire logic                    rst_n,
	input  wire logic signed [CORDW-1:0] sprx,  // taken at frame start
	input  wire logic signed [CORDW-1:0] spry,
	output      logic                    vga_hsync,
	output      logic                    vga_vsync,
	output      logic                    vga_de,
	output      logic [4:0]              vga_r,
	output      logic [5:0]              vga_g,
	output      logic [4:0]              vga_b
);

	display_if disp ();  // coordinates and strobes

	logic [SPR_ADDRW-1:0] rom_addr;
	logic [SPR_WIDTH-1:0] rom_data;
	logic drawing;  // sprite covers the pixel
	logic pix;      // bitmap bit

	display_timing timing_inst (
		.clk_pix,
		.rst_n,
		.disp(disp)
	);

	sprite_fsm sprite_inst (
		.clk_pix,
		.rst_n,
		.disp(disp),
		.sprx,
		.spry,
		.rom_addr,
		.rom_data,
		.drawing,
		.pix
	);

	sprite_rom rom_inst (
		.clk_pix,
		.rom_addr,
		.rom_data
	);

	// two cycles from coordinate to pins
	colour_paint paint_inst (
		.clk_pix,
		.rst_n,
		.disp(disp),
		.drawing,
		.pix,
		.vga_hsync,
		.vga_vsync,
		.vga_de,
		.vga_r,
		.vga_g,
		.vga_b
	);

endmodule

`default_nettype wire

/* bench/tb_sprite_display.sv */
// directed testbench for the sprite display
// reference frame model, reset and geometry checks, timeout and summary
`default_nettype none

module tb_sprite_display import sprite_pkg::*; ();

	localparam int LINE_CYCLES  = H_RES + H_FP + H_SYNC + H_BP;  // 525
	localparam int FRAME_LINES  = V_RES + V_FP + V_SYNC + V_BP;  // 286
	localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
	localparam int TIMEOUT      = 6 * FRAME_CYCLES + 1000;  // five captures plus lead-in
	localparam int MID_FRAME    = (V_RES / 2) * H_RES + H_RES / 2;  // where position moves

	logic clk_pix;
	logic rst_n;
	logic signed [CORDW-1:0] sprx;
	logic signed [CORDW-1:0] spry;
	logic vga_hsync;
	logic vga_vsync;
	logic vga_de;
	logic [4:0] vga_r;
	logic [5:0] vga_g;
	logic [4:0] vga_b;

	logic [SPR_WIDTH-1:0] bitmap [SPR_HEIGHT];  // reference copy of the letter
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int unsigned seed;

	sprite_display_top DUT (
		.clk_pix,
		.rst_n,
		.sprx,
		.spry,
		.vga_hsync,
		.vga_vsync,
		.vga_de,
		.vga_r,
		.vga_g,
		.vga_b
	);

	initial clk_pix = 1'b0;
	always #4 clk_pix = ~clk_pix;  // period 8

	// run limit
	always @(posedge clk_pix) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// 8x scaled letter at (px, py) over a blue field
	function automatic logic [15:0] expected_colour(input int x, input int y,
			input int px, input int py);
		int col;
		int row;
		if (x < px || x >= px + SPR_W_PIX || y < py || y >= py + SPR_H_PIX) begin
			return COL_BG;
		end
		col = (x - px) / 8;
		row = (y - py) / 8;
		return bitmap[row][SPR_WIDTH-1-col] ? COL_FG : COL_BG;  // msb is column 0
	endfunction

	task automatic check_idle_outputs(input string name);
		compare_value({name, " de"}, 0, vga_de);
		compare_value({name, " hsync"}, 1, vga_hsync);
		compare_value({name, " vsync"}, 1, vga_vsync);
		compare_value({name, " colour"}, 0, {vga_r, vga_g, vga_b});
	endtask

	task automatic reset_test();
		rst_n = 1'b0;
		repeat (2) begin
			@(negedge clk_pix);
			check_idle_outputs("reset");
		end
		rst_n = 1'b1;
		@(negedge clk_pix);  // first cycle out of reset
		check_idle_outputs("reset release");
	endtask

	task automatic wait_vsync_fall();
		logic prev;
		prev = vga_vsync;
		@(negedge clk_pix);
		while (!(prev && !vga_vsync)) begin
			prev = vga_vsync;
			@(negedge clk_pix);
		end
	endtask

	// one frame from vsync fall to vsync fall with an optional position change
	task automatic capture_frame(input string name, input int px, input int py,
			input int change_at, input int nx, input int ny);
		int x;
		int y;
		int total;
		int hs_low;
		int vs_low;
		int hs_pulses;
		int since_de;
		bit vs_checked;
		bit done;
		logic prev_de;
		logic prev_hs;
		logic prev_vs;
		logic [15:0] actual;
		x = 0;
		y = 0;
		total = 0;
		hs_low = 0;
		vs_low = 0;
		hs_pulses = 0;
		since_de = LINE_CYCLES;  // no visible line seen yet
		vs_checked = 1'b0;
		done = 1'b0;
		prev_de = 1'b0;
		prev_hs = 1'b1;
		prev_vs = 1'b1;
		while (!done) begin
			actual = {vga_r, vga_g, vga_b};
			if (vga_de) begin
				compare_value($sformatf("%s pixel %0d,%0d", name, x, y),
					expected_colour(x, y, px, py), actual);
				x++;
				total++;
				since_de = 0;
				if (total == change_at) begin  // latched on the next frame only
					sprx = CORDW'(nx);
					spry = CORDW'(ny);
				end
			end else begin
				compare_value({name, " blanking colour"}, 0, actual);
				since_de++;
				if (prev_de) begin  // end of a visible line
					compare_value({name, " line width"}, H_RES, x);
					x = 0;
					y++;
				end
			end
			if (!vga_hsync) begin
				// sync starts right after the front porch of a visible line
				if (prev_hs && since_de < LINE_CYCLES) begin
					compare_value({name, " hsync position"}, H_FP + 1, since_de);
				end
				hs_low++;
			end else if (!prev_hs) begin
				compare_value({name, " hsync width"}, H_SYNC, hs_low);
				hs_low = 0;
				hs_pulses++;
			end
			if (!vga_vsync) begin
				vs_low++;
			end else if (!prev_vs) begin
				compare_value({name, " vsync width"}, V_SYNC * LINE_CYCLES, vs_low);
				vs_checked = 1'b1;
			end
			prev_de = vga_de;
			prev_hs = vga_hsync;
			prev_vs = vga_vsync;
			@(negedge clk_pix);
			if (prev_vs && !vga_vsync) done = 1'b1;  // next frame starts
		end
		compare_value({name, " line count"}, V_RES, y);
		compare_value({name, " hsync pulses"}, FRAME_LINES, hs_pulses);
		compare_value({name, " vsync position"}, V_FP * LINE_CYCLES, since_de);
		if (!vs_checked) begin
			errors++;
			$display("%s: the vsync pulse never ended during the frame", name);
		end
	endtask

	initial begin
		int rx;
		int ry;
		rst_n = 1'b0;
		sprx = CORDW'(32);
		spry = CORDW'(16);
		$readmemb("logic/letter_f.mem", bitmap);
		seed = 58;
		seed = lcg_next(seed);
		rx = int'((seed >> 8) % 561) - 70;  // -70 to 490
		seed = lcg_next(seed);
		ry = int'((seed >> 8) % 351) - 70;  // -70 to 280

		reset_test();
		wait_vsync_fall();
		// each capture moves the sprite halfway down for the next frame
		capture_frame("onscreen", 32, 16, MID_FRAME, 440, 230);
		capture_frame("clip_right_bottom", 440, 230, MID_FRAME, -40, -24);
		capture_frame("clip_negative", -40, -24, MID_FRAME, rx, ry);
		capture_frame("clip_random", rx, ry, MID_FRAME, 200, 100);
		capture_frame("latch", 200, 100, -1, 200, 100);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/letter_f.mem */
// letter F bitmap, one row per line from the top
// eight binary columns, leftmost digit is column 0
11111110
11000000
11000000
11111100
11000000
11000000
11000000
00000000

/* vlog.f */
logic/sprite_pkg.sv
logic/display_if.sv
logic/display_timing.sv
logic/sprite_fsm.sv
logic/sprite_rom.sv
logic/colour_paint.sv
logic/sprite_display_top.sv
bench/tb_sprite_display.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_sprite_display \
		-o tb_sprite_display > build.log 2>&1 \
	&& ./obj_dir/tb_sprite_display > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "Some tests failed" sim.log \
	&& { echo "simulation FAILED, see sim.log"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
